// ==== include/spi_io_settings.svh ====
`ifndef SPI_IO_SETTINGS_SVH
`define SPI_IO_SETTINGS_SVH

// ------------------------------
// bus geometry
// ------------------------------
`define SPI_IO_ADDR_W     12              // register bus address width
`define SPI_IO_DATA_W     16              // register bus data width
`define SPI_LANES         4               // io0..io3 on each port
`define SPI_PINS_W        6               // cs, sck, io3..io0

// bit positions inside the pin register
`define SPI_PIN_CS        5
`define SPI_PIN_SCK       4

// ------------------------------
// address map
// ------------------------------
`define SPI_EVE_BASE      12'h100         // display controller port
`define SPI_FLASH_BASE    12'h110         // flash port

`define SPI_REG_PINS      12'h000         // bit-bang pins, raw pin readback
`define SPI_REG_START8    12'h001         // 8-bit start, rx readback
`define SPI_REG_START16   12'h002         // 16-bit start, rx readback
`define SPI_REG_IDLE      12'h003         // idle readback
`define SPI_REG_DIR       12'h004         // quad direction
`define SPI_REG_QUAD      12'h005         // quad mode enable

`define SYS_SYSCTL_ADDR   12'h014
`define SYS_TICKS_ADDR    12'h015

// ------------------------------
// reset values
// ------------------------------
`define SPI_PINS_RESET    6'b10_0000      // cs deasserted, everything else low
`define SYS_SYSCTL_RESET  16'h0000        // display powered down pin low

`endif

// ==== hw/spi_io_pkg.sv ====
`include "spi_io_settings.svh"

package spi_io_pkg;

  // one bus data word
  typedef logic [`SPI_IO_DATA_W-1:0] io_word_t;

  // one bit per spi lane, bit 0 is mosi and bit 1 is miso
  typedef logic [`SPI_LANES-1:0] spi_lanes_t;

  // ------------------------------
  // register bus request
  // ------------------------------
  typedef struct packed {
    logic                      rd;      // read strobe
    logic                      wr;      // write strobe
    logic [`SPI_IO_ADDR_W-1:0] addr;    // register address
    io_word_t                  wdata;   // write data
  } io_req_t;

  // ------------------------------
  // pad side of one spi port
  // ------------------------------
  typedef struct packed {
    logic       cs;                     // chip select, active low
    logic       sck;                    // serial clock
    spi_lanes_t dout;                   // value driven on io3..io0
    spi_lanes_t oe;                     // 1 = lane driven by this side
  } spi_pads_t;

endpackage

// ==== hw/spi_engine.sv ====
`timescale 1ns/1ps

module spi_engine
  import spi_io_pkg::*;
(
  input  logic       pclk,
  input  logic       SCKclock,
  input  logic       start8_i,
  input  logic       start16_i,
  input  logic       quad_i,
  input  io_word_t   tx_i,
  input  spi_lanes_t din_i,
  output io_word_t   rx_o,
  output logic       busy_o,
  output logic       sck_o,
  output spi_lanes_t dout_o
);

  logic       running;
  logic [4:0] phase;
  logic [4:0] phase_nxt;
  logic       sck;
  logic       start;
  io_word_t   tx_swap;
  io_word_t   shifter;

  assign start     = start8_i | start16_i;
  assign phase_nxt = phase + (quad_i ? 5'd4 : 5'd1);   // one or four bits per step
  assign tx_swap   = {tx_i[7:0], tx_i[15:8]};          // low byte leaves first
  assign sck       = quad_i ? phase[2] : phase[0];

  // ------------------------------
  // transfer sequencing
  // ------------------------------
  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      running <= 1'b0;
      phase   <= 5'd0;
    end else if (start8_i) begin
      running <= 1'b1;
      phase   <= 5'd16;                                // only half a lap for 8 bits
    end else if (start16_i) begin
      running <= 1'b1;
      phase   <= 5'd0;
    end else if (running) begin
      running <= (phase_nxt != 5'd0);                  // done when the counter wraps
      phase   <= phase_nxt;
    end
  end

  // ------------------------------
  // data shifter
  // ------------------------------
  always_ff @(posedge pclk) begin
    if (start) begin
      shifter <= tx_swap;
    end else if (running && sck) begin                 // sample at end of sck high
      if (quad_i) begin
        shifter <= {shifter[11:0], din_i};
      end else begin
        shifter <= {shifter[14:0], din_i[1]};          // miso only
      end
    end
  end

  assign rx_o   = shifter;
  assign busy_o = running;
  assign sck_o  = sck;                                 // phase sits at zero while idle

  // msb of the shifter is on the wire, quiet when idle so the pin register rules
  always_comb begin
    if (!running) begin
      dout_o = '0;
    end else if (quad_i) begin
      dout_o = shifter[15:12];
    end else begin
      dout_o = {3'b000, shifter[15]};
    end
  end

endmodule

// ==== hw/spi_port.sv ====
`timescale 1ns/1ps
`include "spi_io_settings.svh"

module spi_port
  import spi_io_pkg::*;
#(
  parameter logic [`SPI_IO_ADDR_W-1:0] BASE = `SPI_EVE_BASE
) (
  input  logic       pclk,
  input  logic       SCKclock,
  input  io_req_t    io_req_i,
  input  spi_lanes_t pins_i,
  output spi_pads_t  pads_o,
  output io_word_t   rdata_o
);

  // ------------------------------
  // address decode
  // ------------------------------
  localparam logic [`SPI_IO_ADDR_W-1:0] A_PINS    = BASE + `SPI_REG_PINS;
  localparam logic [`SPI_IO_ADDR_W-1:0] A_START8  = BASE + `SPI_REG_START8;
  localparam logic [`SPI_IO_ADDR_W-1:0] A_START16 = BASE + `SPI_REG_START16;
  localparam logic [`SPI_IO_ADDR_W-1:0] A_IDLE    = BASE + `SPI_REG_IDLE;
  localparam logic [`SPI_IO_ADDR_W-1:0] A_DIR     = BASE + `SPI_REG_DIR;
  localparam logic [`SPI_IO_ADDR_W-1:0] A_QUAD    = BASE + `SPI_REG_QUAD;

  logic                   wr_pins;
  logic                   wr_dir;
  logic                   wr_quad;
  logic                   start8;
  logic                   start16;

  logic [`SPI_PINS_W-1:0] pins_q;                      // cs, sck, io3..io0
  logic                   dir_q;
  logic                   quad_q;

  io_word_t               eng_rx;
  logic                   eng_busy;
  logic                   eng_sck;
  spi_lanes_t             eng_dout;
  logic                   idle;

  assign wr_pins = io_req_i.wr & (io_req_i.addr == A_PINS);
  assign wr_dir  = io_req_i.wr & (io_req_i.addr == A_DIR);
  assign wr_quad = io_req_i.wr & (io_req_i.addr == A_QUAD);
  assign start8  = io_req_i.wr & (io_req_i.addr == A_START8);
  assign start16 = io_req_i.wr & (io_req_i.addr == A_START16);

  // ------------------------------
  // control registers
  // ------------------------------
  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      pins_q <= `SPI_PINS_RESET;
      dir_q  <= 1'b0;
      quad_q <= 1'b0;                                  // single-bit mode out of reset
    end else begin
      if (wr_pins) begin
        pins_q <= io_req_i.wdata[`SPI_PINS_W-1:0];
      end
      if (wr_dir) begin
        dir_q <= io_req_i.wdata[0];
      end
      if (wr_quad) begin
        quad_q <= io_req_i.wdata[0];
      end
    end
  end

  spi_engine u_engine (
    .pclk      (pclk),
    .SCKclock  (SCKclock),
    .start8_i  (start8),
    .start16_i (start16),
    .quad_i    (quad_q),
    .tx_i      (io_req_i.wdata),                       // tx word is the start write data
    .din_i     (pins_i),
    .rx_o      (eng_rx),
    .busy_o    (eng_busy),
    .sck_o     (eng_sck),
    .dout_o    (eng_dout)
  );

  // ------------------------------
  // pad forming
  // ------------------------------
  always_comb begin
    pads_o.cs   = pins_q[`SPI_PIN_CS];
    pads_o.sck  = pins_q[`SPI_PIN_SCK] | eng_sck;
    pads_o.dout = pins_q[`SPI_LANES-1:0] | eng_dout;
    if (quad_q) begin
      pads_o.oe = {`SPI_LANES{dir_q}};                 // all lanes out, or all in
    end else begin
      pads_o.oe = 4'b0001;                             // mosi only
    end
  end

  // ------------------------------
  // readback
  // ------------------------------
  assign idle = ~eng_busy;

  always_comb begin
    rdata_o = '0;
    if (io_req_i.rd) begin
      case (io_req_i.addr)
        A_PINS:    rdata_o = {{(`SPI_IO_DATA_W-`SPI_LANES){1'b0}}, pins_i};  // raw levels
        A_START8:  rdata_o = eng_rx;
        A_START16: rdata_o = eng_rx;
        A_IDLE:    rdata_o = {{(`SPI_IO_DATA_W-1){1'b0}}, idle};
        default:   rdata_o = '0;                       // dir and quad are write only
      endcase
    end
  end

endmodule

// ==== hw/sys_regs.sv ====
`timescale 1ns/1ps
`include "spi_io_settings.svh"

module sys_regs
  import spi_io_pkg::*;
(
  input  logic     pclk,
  input  logic     SCKclock,
  input  io_req_t  io_req_i,
  output logic     pd_o,
  output io_word_t rdata_o
);

  io_word_t ticks;
  io_word_t sysctl;
  logic     wr_sysctl;

  assign wr_sysctl = io_req_i.wr & (io_req_i.addr == `SYS_SYSCTL_ADDR);

  // ------------------------------
  // free-running tick counter
  // ------------------------------
  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      ticks <= '0;
    end else begin
      ticks <= ticks + 1'b1;                           // wraps silently
    end
  end

  // ------------------------------
  // system control
  // ------------------------------
  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      sysctl <= `SYS_SYSCTL_RESET;
    end else if (wr_sysctl) begin
      sysctl <= io_req_i.wdata;
    end
  end

  assign pd_o = sysctl[0];                             // display power-down pin

  always_comb begin
    rdata_o = '0;
    if (io_req_i.rd) begin
      case (io_req_i.addr)
        `SYS_SYSCTL_ADDR: rdata_o = sysctl;
        `SYS_TICKS_ADDR:  rdata_o = ticks;
        default:          rdata_o = '0;
      endcase
    end
  end

endmodule

// ==== hw/spi_io_top.sv ====
`timescale 1ns/1ps
`include "spi_io_settings.svh"

module spi_io_top
  import spi_io_pkg::*;
(
  input  logic       pclk,
  input  logic       SCKclock,
  input  io_req_t    io_req_i,
  input  spi_lanes_t eve_pins_i,
  input  spi_lanes_t flash_pins_i,
  output io_word_t   io_rdata_o,
  output spi_pads_t  eve_pads_o,
  output spi_pads_t  flash_pads_o,
  output logic       pd_o
);

  io_word_t eve_rdata;
  io_word_t flash_rdata;
  io_word_t sys_rdata;

  // ------------------------------
  // spi ports
  // ------------------------------
  spi_port #(
    .BASE (`SPI_EVE_BASE)
  ) u_eve_port (
    .pclk     (pclk),
    .SCKclock (SCKclock),
    .io_req_i (io_req_i),
    .pins_i   (eve_pins_i),
    .pads_o   (eve_pads_o),
    .rdata_o  (eve_rdata)
  );

  spi_port #(
    .BASE (`SPI_FLASH_BASE)
  ) u_flash_port (
    .pclk     (pclk),
    .SCKclock (SCKclock),
    .io_req_i (io_req_i),
    .pins_i   (flash_pins_i),
    .pads_o   (flash_pads_o),
    .rdata_o  (flash_rdata)
  );

  // ------------------------------
  // system block
  // ------------------------------
  sys_regs u_sys_regs (
    .pclk     (pclk),
    .SCKclock (SCKclock),
    .io_req_i (io_req_i),
    .pd_o     (pd_o),
    .rdata_o  (sys_rdata)
  );

  // each block returns zero outside its own addresses
  assign io_rdata_o = eve_rdata | flash_rdata | sys_rdata;

endmodule

// ==== tb/spi_dev_model.sv ====
`timescale 1ns/1ps

module spi_dev_model
  import spi_io_pkg::*;
(
  input  logic        pclk,
  input  spi_pads_t   pads_i,
  input  logic [63:0] stream_i,     // nibble k sits at bits 4k+3..4k
  output spi_lanes_t  pins_o,
  output io_word_t    rec_bits_o,   // mosi taken on each sck-high cycle
  output io_word_t    rec_nibs_o    // all four lanes taken on each sck-high cycle
);

  logic [3:0] idx;
  spi_lanes_t nib;

  assign nib = stream_i[{idx, 2'b00} +: 4];

  // ------------------------------
  // pin loopback
  // ------------------------------
  // lanes the port drives come straight back, the rest carry the stream
  assign pins_o = (pads_i.oe & pads_i.dout) | (~pads_i.oe & nib);

  // ------------------------------
  // stream position and recording
  // ------------------------------
  always_ff @(posedge pclk) begin
    if (pads_i.cs) begin                              // deselected, back to the start
      idx        <= 4'd0;
      rec_bits_o <= '0;
      rec_nibs_o <= '0;
    end else if (pads_i.sck) begin
      idx        <= idx + 4'd1;                       // next nibble after each pulse
      rec_bits_o <= {rec_bits_o[14:0], pads_i.dout[0]};
      rec_nibs_o <= {rec_nibs_o[11:0], pads_i.dout};
    end
  end

endmodule

// ==== tb/tb_spi_io.sv ====
`timescale 1ns/1ps
`include "spi_io_settings.svh"

module tb_spi_io
  import spi_io_pkg::*;
();

  localparam int SEED        = 8670;
  localparam int N_WORDS     = 20;
  localparam int XFER_CYCLES = 2 * N_WORDS * 40;      // at most 40 cycles a word on both ports
  localparam int MAX_CYCLES  = 2 * XFER_CYCLES + 800;  // room for the short tests

  logic        pclk = 1'b0;
  logic        SCKclock;
  io_req_t     io_req;
  spi_lanes_t  eve_pins;
  spi_lanes_t  flash_pins;
  io_word_t    io_rdata;
  spi_pads_t   eve_pads;
  spi_pads_t   flash_pads;
  logic        pd;
  logic [63:0] eve_stream;
  logic [63:0] flash_stream;
  io_word_t    eve_rec_bits;
  io_word_t    eve_rec_nibs;
  io_word_t    flash_rec_bits;
  io_word_t    flash_rec_nibs;

  string       name_q[$];
  io_word_t    got_q[$];
  io_word_t    exp_q[$];
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_errors = 0;
  int          tests = 0;

  always #20 pclk = ~pclk;                            // 40 ns period

  spi_io_top dut (
    .pclk         (pclk),
    .SCKclock     (SCKclock),
    .io_req_i     (io_req),
    .eve_pins_i   (eve_pins),
    .flash_pins_i (flash_pins),
    .io_rdata_o   (io_rdata),
    .eve_pads_o   (eve_pads),
    .flash_pads_o (flash_pads),
    .pd_o         (pd)
  );

  spi_dev_model eve_dev (
    .pclk       (pclk),
    .pads_i     (eve_pads),
    .stream_i   (eve_stream),
    .pins_o     (eve_pins),
    .rec_bits_o (eve_rec_bits),
    .rec_nibs_o (eve_rec_nibs)
  );

  spi_dev_model flash_dev (
    .pclk       (pclk),
    .pads_i     (flash_pads),
    .stream_i   (flash_stream),
    .pins_o     (flash_pins),
    .rec_bits_o (flash_rec_bits),
    .rec_nibs_o (flash_rec_nibs)
  );

  // ------------------------------
  // compare and watchdog
  // ------------------------------
  always @(negedge pclk) begin
    while (name_q.size() > 0) begin
      checks++;
      assert (got_q[0] === exp_q[0]) else begin
        $display("ERROR %s: got 0x%h, expected 0x%h", name_q[0], got_q[0], exp_q[0]);
        errors++;
        test_errors++;
      end
      void'(name_q.pop_front());
      void'(got_q.pop_front());
      void'(exp_q.pop_front());
    end
  end

  always @(posedge pclk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ------------------------------
  // expected values
  // ------------------------------
  // received bits pile up msb first
  // an 8-bit transfer keeps tx[15:8] on top
  function automatic io_word_t expected_rx(input io_word_t tx, input logic quad,
                                           input logic wide, input logic [63:0] stream);
    int       n_bits;
    int       k;
    io_word_t r;
    n_bits = wide ? 16 : 8;
    r = '0;
    if (quad) begin
      for (k = 0; k < n_bits / 4; k++) begin
        r = {r[11:0], stream[4*k +: 4]};              // one nibble per pulse
      end
    end else begin
      for (k = 0; k < n_bits; k++) begin
        r = {r[14:0], stream[4*k+1]};                 // miso lane of each nibble
      end
    end
    if (!wide) begin
      r = {tx[15:8], r[7:0]};
    end
    return r;
  endfunction

  // bits leave low byte first and msb first and pile up from the bottom
  function automatic io_word_t expected_sent(input io_word_t tx, input logic wide);
    int       n_bits;
    int       k;
    io_word_t r;
    n_bits = wide ? 16 : 8;
    r = '0;
    for (k = 0; k < n_bits; k++) begin
      if (k < 8) begin
        r = {r[14:0], tx[7 - k]};                     // low byte
      end else begin
        r = {r[14:0], tx[23 - k]};                    // high byte
      end
    end
    return r;
  endfunction

  function automatic io_word_t rand16();
    int unsigned r;
    r = $urandom;
    return r[15:0];
  endfunction

  // ------------------------------
  // bus tasks enter and leave 1 ns after a rising edge
  // ------------------------------
  task automatic queue_check(input string name, input io_word_t got, input io_word_t exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  task automatic write_reg(input logic [11:0] addr, input io_word_t data);
    io_req.rd    = 1'b0;
    io_req.wr    = 1'b1;
    io_req.addr  = addr;
    io_req.wdata = data;
    @(posedge pclk);
    #1;
    io_req.wr = 1'b0;
  endtask

  task automatic read_reg(input logic [11:0] addr, output io_word_t data);
    io_req.rd   = 1'b1;
    io_req.addr = addr;
    #5;
    data = io_rdata;
    @(posedge pclk);
    #1;
    io_req.rd = 1'b0;
  endtask

  task automatic wait_idle(input logic [11:0] base, output int n, output logic first_idle);
    n = 0;
    io_req.rd   = 1'b1;
    io_req.addr = base + `SPI_REG_IDLE;
    #5;
    first_idle = io_rdata[0];
    while (io_rdata[0] !== 1'b1) begin
      @(posedge pclk);
      #6;
      n++;
    end
    @(posedge pclk);
    #1;
    io_req.rd = 1'b0;
  endtask

  task automatic run_xfer(input logic [11:0] base, input logic quad, input logic dir,
                          input logic wide, input io_word_t tx);
    int          n;
    logic        first_idle;
    logic [63:0] stream;
    logic [11:0] start_addr;
    io_word_t    rx;
    io_word_t    exp_cycles;
    logic [3:0]  exp_oe;
    spi_pads_t   pads;
    io_word_t    rec_bits;
    io_word_t    rec_nibs;
    string       port;

    stream     = {rand16(), rand16(), rand16(), rand16()};
    start_addr = base + (wide ? `SPI_REG_START16 : `SPI_REG_START8);
    exp_cycles = quad ? (wide ? 16'd8 : 16'd4) : (wide ? 16'd32 : 16'd16);
    exp_oe     = quad ? {4{dir}} : 4'b0001;
    if (base == `SPI_EVE_BASE) begin
      port       = "eve";
      eve_stream = stream;
    end else begin
      port         = "flash";
      flash_stream = stream;
    end
    write_reg(base + `SPI_REG_PINS, 16'h0000);       // chip select low
    write_reg(start_addr, tx);
    wait_idle(base, n, first_idle);
    if (base == `SPI_EVE_BASE) begin
      pads     = eve_pads;
      rec_bits = eve_rec_bits;
      rec_nibs = eve_rec_nibs;
    end else begin
      pads     = flash_pads;
      rec_bits = flash_rec_bits;
      rec_nibs = flash_rec_nibs;
    end
    queue_check({port, " idle after start"}, {15'h0000, first_idle}, 16'h0000);
    queue_check({port, " busy cycles"}, n[15:0], exp_cycles);
    queue_check({port, " pads.oe"}, {12'h000, pads.oe}, {12'h000, exp_oe});
    if (quad && dir) begin
      queue_check({port, " rec_nibs"}, rec_nibs, expected_sent(tx, wide));
    end else begin
      if (!quad) begin
        queue_check({port, " rec_bits"}, rec_bits, expected_sent(tx, wide));
      end
      read_reg(start_addr, rx);
      queue_check({port, " rx"}, rx, expected_rx(tx, quad, wide, stream));
    end
    write_reg(base + `SPI_REG_PINS, {10'h000, `SPI_PINS_RESET});
  endtask

  task automatic finish_test(input string name);
    @(negedge pclk);                                  // compare process empties the queue here
    @(posedge pclk);
    #1;
    tests++;
    $display("test %0d %s: %s (%0d errors)", tests, name,
             (test_errors == 0) ? "ok" : "failed", test_errors);
    test_errors = 0;
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    io_word_t   word;
    io_word_t   word2;
    io_word_t   snap_rx;
    spi_pads_t  snap_pads;
    logic [3:0] d;
    int         gap;
    int         i;

    void'($urandom(SEED));
    SCKclock     = 1'b1;
    io_req       = '0;
    eve_stream   = '0;
    flash_stream = '0;
    repeat (2) @(posedge pclk);
    #1 SCKclock = 1'b0;

    read_reg(`SPI_EVE_BASE + `SPI_REG_IDLE, word);
    queue_check("eve idle", word, 16'h0001);
    read_reg(`SPI_FLASH_BASE + `SPI_REG_IDLE, word);
    queue_check("flash idle", word, 16'h0001);
    queue_check("eve pads", {6'h00, eve_pads}, 16'h0201);    // cs high and oe on mosi only
    queue_check("flash pads", {6'h00, flash_pads}, 16'h0201);
    read_reg(`SYS_SYSCTL_ADDR, word);
    queue_check("sysctl", word, 16'h0000);
    queue_check("pd_o", {15'h0000, pd}, 16'h0000);
    finish_test("reset values");

    for (i = 0; i < 2 * N_WORDS; i++) begin
      run_xfer((i < N_WORDS) ? `SPI_EVE_BASE : `SPI_FLASH_BASE, 1'b0, 1'b0, i[0], rand16());
    end
    finish_test("single-mode transfers");

    write_reg(`SPI_EVE_BASE + `SPI_REG_QUAD, 16'h0001);
    write_reg(`SPI_EVE_BASE + `SPI_REG_DIR, 16'h0001);
    run_xfer(`SPI_EVE_BASE, 1'b1, 1'b1, 1'b0, rand16());
    run_xfer(`SPI_EVE_BASE, 1'b1, 1'b1, 1'b1, rand16());
    write_reg(`SPI_EVE_BASE + `SPI_REG_DIR, 16'h0000);      // lanes turn to inputs
    run_xfer(`SPI_EVE_BASE, 1'b1, 1'b0, 1'b0, rand16());
    run_xfer(`SPI_EVE_BASE, 1'b1, 1'b0, 1'b1, rand16());
    write_reg(`SPI_EVE_BASE + `SPI_REG_QUAD, 16'h0000);
    finish_test("quad transfers");

    flash_stream = {rand16(), rand16(), rand16(), rand16()};
    word = rand16();
    d    = word[3:0];
    write_reg(`SPI_FLASH_BASE + `SPI_REG_PINS, {10'h000, 2'b01, d});
    queue_check("flash cs/sck/dout", {10'h000, flash_pads.cs, flash_pads.sck, flash_pads.dout},
                {10'h000, 2'b01, d});
    write_reg(`SPI_FLASH_BASE + `SPI_REG_PINS, {10'h000, 2'b10, ~d});
    @(posedge pclk);                                  // model rewinds while cs is high
    #1;
    queue_check("flash cs/sck/dout", {10'h000, flash_pads.cs, flash_pads.sck, flash_pads.dout},
                {10'h000, 2'b10, ~d});
    read_reg(`SPI_FLASH_BASE + `SPI_REG_PINS, word);
    queue_check("flash pins", word, {12'h000, flash_stream[3:1], ~d[0]});
    write_reg(`SPI_FLASH_BASE + `SPI_REG_PINS, {10'h000, `SPI_PINS_RESET});
    finish_test("bit-bang pins");

    word = rand16() | 16'h0001;
    write_reg(`SYS_SYSCTL_ADDR, word);
    read_reg(`SYS_SYSCTL_ADDR, word2);
    queue_check("sysctl", word2, word);
    queue_check("pd_o", {15'h0000, pd}, 16'h0001);
    write_reg(`SYS_SYSCTL_ADDR, 16'h0000);
    queue_check("pd_o", {15'h0000, pd}, 16'h0000);
    gap = $urandom_range(41, 2);
    read_reg(`SYS_TICKS_ADDR, word);
    repeat (gap - 1) @(posedge pclk);
    #1;
    read_reg(`SYS_TICKS_ADDR, word2);
    queue_check("tick delta", word2 - word, gap[15:0]);
    finish_test("system registers");

    read_reg(`SPI_EVE_BASE + `SPI_REG_START16, snap_rx);
    snap_pads = eve_pads;
    run_xfer(`SPI_FLASH_BASE, 1'b0, 1'b0, 1'b1, rand16());
    read_reg(`SPI_EVE_BASE + `SPI_REG_START16, word);
    queue_check("eve rx", word, snap_rx);
    queue_check("eve pads", {6'h00, eve_pads}, {6'h00, snap_pads});
    read_reg(`SPI_EVE_BASE + `SPI_REG_IDLE, word);
    queue_check("eve idle", word, 16'h0001);
    finish_test("port independence");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
hw/spi_io_pkg.sv
hw/spi_engine.sv
hw/spi_port.sv
hw/sys_regs.sv
hw/spi_io_top.sv
tb/spi_dev_model.sv
tb/tb_spi_io.sv

// ==== Makefile ====
# Verilator build and run for the SPI I/O block

VERILATOR ?= verilator
TOP       ?= tb_spi_io
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= SIMULATION PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
